// ==== Makefile ====
# Verilator build for the memory glue testbench

TOP = tb_jag_mem_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f jag_mem.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/bios_rom.sv ====
/* Boot ROM with checksum patch */
module bios_rom (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  jag_mem_pkg::ioctl_t  ioctl,
	input  jag_mem_pkg::abus_t   abus,
	input  logic                 patch_en,
	output jag_mem_pkg::byte_t   bios_q
);

	// 128 KiB of bytes
	jag_mem_pkg::byte_t mem [0:(1 << $bits(jag_mem_pkg::bios_addr_t)) - 1];

	logic                 boot_idx;
	logic                 wr_hit;
	logic                 wr_en;     // Byte write this cycle
	logic                 wr_hi;     // Phase, 0 low byte then 1 high byte
	logic [15:0]          wr_base;   // Word address, ioctl addr 16..1
	jag_mem_pkg::word16_t wr_word;
	jag_mem_pkg::byte_t   rd_q;
	logic                 patch_hit;

	// Either boot slot fills the same ROM
	assign boot_idx = ioctl.download &&
		((ioctl.index[5:0] == jag_mem_pkg::IDX_BIOS_A) ||
		(ioctl.index[5:0] == jag_mem_pkg::IDX_BIOS_B));
	assign wr_hit = ioctl.wr && boot_idx;

	// ========================================
	// Word to byte writer
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_en <= 1'b0;
			wr_hi <= 1'b0;
		end else if (wr_hit) begin
			wr_en <= 1'b1;
			wr_hi <= 1'b0;   // Low byte first
		end else if (wr_en && !wr_hi) begin
			wr_hi <= 1'b1;
		end else begin
			wr_en <= 1'b0;   // Both halves written
			wr_hi <= 1'b0;
		end
	end

	// Word and position held for both phases
	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			wr_base <= ioctl.addr[16:1];
			wr_word <= ioctl.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[{wr_base, wr_hi}] <= wr_hi ? wr_word[15:8] : wr_word[7:0];
	end

	// ========================================
	// Console read side
	// ========================================
	always_ff @(posedge clk_sys) begin
		rd_q <= mem[abus[16:0]];  // One cycle read
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			patch_hit <= 1'b0;
		else
			patch_hit <= patch_en && (abus[16:0] == jag_mem_pkg::PATCH_ADDR);
	end

	// Branch over the cart checksum test
	assign bios_q = patch_hit ? jag_mem_pkg::PATCH_BYTE : rd_q;

endmodule

// ==== design/cart_loader.sv ====
/* Cartridge loader into DDR */
module cart_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  jag_mem_pkg::ioctl_t   ioctl,
	input  logic                  load_accept,
	output jag_mem_pkg::ddr_req_t load_req,
	output logic                  load_active,
	output logic                  ioctl_wait
);

	logic                 old_download;  // Download level last cycle
	logic                 load_en;       // Cart download in progress
	logic                 req_valid;     // One write waiting for the arbiter
	logic                 cart_idx;
	logic                 dl_start;
	logic                 dl_end;
	logic                 wr_hit;
	jag_mem_pkg::abus_t   load_addr;     // Running byte address
	jag_mem_pkg::word16_t load_word;     // Swapped copy of the host word
	jag_mem_pkg::ddr_be_t load_be;

	assign cart_idx = ioctl.index[5:0] == jag_mem_pkg::IDX_CART;
	assign dl_start = ioctl.download && !old_download && cart_idx;  // Rising edge, cart slot
	assign dl_end   = old_download && !ioctl.download;              // Any download end
	assign wr_hit   = ioctl.wr && cart_idx;

	// ========================================
	// Control
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			load_en      <= 1'b0;
			req_valid    <= 1'b0;
			ioctl_wait   <= 1'b0;
			load_addr    <= jag_mem_pkg::CART_BASE;
		end else begin
			old_download <= ioctl.download;

			// Restart at the cart base on every new image
			if (dl_start) begin
				load_addr <= jag_mem_pkg::CART_BASE;
				load_en   <= 1'b1;
			end else if (load_accept) begin
				load_addr <= load_addr + jag_mem_pkg::abus_t'(2);  // One 16-bit word done
			end

			if (wr_hit) begin
				req_valid  <= 1'b1;
				ioctl_wait <= 1'b1;  // Hold the host off until DDR takes it
			end else if (load_accept) begin
				req_valid  <= 1'b0;
				ioctl_wait <= 1'b0;
			end

			if (dl_end) begin
				load_en    <= 1'b0;
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Host data arrives little end first
	always_ff @(posedge clk_sys) begin
		if (wr_hit)
			load_word <= {ioctl.data[7:0], ioctl.data[15:8]};
	end

	// Lane select from word position in the 64-bit line
	always_comb begin
		case (load_addr[2:1])
			2'd0:    load_be = 8'b1100_0000;
			2'd1:    load_be = 8'b0011_0000;
			2'd2:    load_be = 8'b0000_1100;
			default: load_be = 8'b0000_0011;
		endcase
	end

	assign load_req = '{valid: req_valid, we: 1'b1, addr: load_addr,
		din: {4{load_word}}, be: load_be};  // Same word on all lanes

	assign load_active = load_en || req_valid;  // Keeps the grant until the last write lands

endmodule

// ==== design/cart_reader.sv ====
/* Cartridge reads from DDR */
module cart_reader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  jag_mem_pkg::abus_t      abus,
	input  logic                    cart_ce_n,
	input  logic                    read_accept,
	input  jag_mem_pkg::ddr_data_t  ddr_dout,
	input  logic                    ddr_dout_ready,
	output jag_mem_pkg::ddr_req_t   read_req,
	output logic                    cart_wait,
	output jag_mem_pkg::cart_data_t cart_q
);

	logic               prev_ce_n;   // Select one cycle back
	jag_mem_pkg::abus_t prev_abus;   // Address one cycle back
	logic               trigger;
	logic               start;
	logic               rd_pending;  // Request not yet taken by the arbiter
	logic               wait_latch;  // Read in flight, console stalled
	jag_mem_pkg::abus_t rd_addr;

	// New access: select just fell, or address moved while selected
	assign trigger = !cart_ce_n && (prev_ce_n || (abus != prev_abus));

	// Console is stalled during a read so nothing new can show up
	assign start = trigger && !wait_latch;

	// ========================================
	// Request and wait tracking
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			prev_ce_n  <= 1'b1;
			prev_abus  <= '0;
			rd_pending <= 1'b0;
			wait_latch <= 1'b0;
		end else begin
			prev_ce_n <= cart_ce_n;
			prev_abus <= abus;

			if (start) begin
				rd_pending <= 1'b1;
				wait_latch <= 1'b1;
			end else begin
				if (read_accept)
					rd_pending <= 1'b0;
				if (ddr_dout_ready)
					wait_latch <= 1'b0;  // Data back, let the console go
			end
		end
	end

	// Address captured with the trigger
	always_ff @(posedge clk_sys) begin
		if (start)
			rd_addr <= abus;
	end

	// Enables are forced by the arbiter on reads
	assign read_req = '{valid: rd_pending, we: 1'b0, addr: rd_addr,
		din: '0, be: '1};

	// Drop wait in the data cycle itself
	assign cart_wait = wait_latch && !ddr_dout_ready;

	// 32-bit cart bus, bit 2 picks the half
	assign cart_q = !abus[2] ? ddr_dout[63:32] : ddr_dout[31:0];

endmodule

// ==== design/ddr_arbiter.sv ====
/* DDR port arbiter */
module ddr_arbiter (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  jag_mem_pkg::ddr_req_t  load_req,
	input  logic                   load_active,
	input  jag_mem_pkg::ddr_req_t  read_req,
	input  logic                   ddr_busy,
	output logic                   load_accept,
	output logic                   read_accept,
	output jag_mem_pkg::ddr_addr_t ddr_addr,
	output logic                   ddr_rd,
	output logic                   ddr_we,
	output jag_mem_pkg::ddr_data_t ddr_din,
	output jag_mem_pkg::ddr_be_t   ddr_be
);

	logic                  grant_load;  // 1 = loader owns the port
	logic                  pend;        // Granted side has something to send
	logic                  go;          // Access issued this cycle
	jag_mem_pkg::ddr_req_t sel;

	// Reader is never eligible during a load
	assign pend = grant_load ? load_req.valid : (read_req.valid && !load_active);
	assign go   = pend && !ddr_busy;

	// ========================================
	// Grant
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			grant_load <= 1'b0;
		end else if (!pend) begin
			grant_load <= load_active;  // Switch only between requests
		end
	end

	assign load_accept = go && grant_load;
	assign read_accept = go && !grant_load;

	assign sel = grant_load ? load_req : read_req;

	// ========================================
	// DDR side
	// ========================================
	assign ddr_addr = {jag_mem_pkg::DDR_REGION, sel.addr[23:3]};  // 64-bit word address
	assign ddr_we   = go && sel.we;
	assign ddr_rd   = go && !sel.we;
	assign ddr_din  = sel.din;
	assign ddr_be   = sel.we ? sel.be : '1;  // Controller wants all lanes on reads

endmodule

// ==== design/jag_mem_pkg.sv ====
/* Memory glue shared types */
package jag_mem_pkg;

	// ========================================
	// Widths with a meaning
	// ========================================
	typedef logic [15:0] word16_t;     // Host download word
	typedef logic [7:0]  byte_t;       // Boot-ROM byte
	typedef logic [23:0] abus_t;       // Console byte address
	typedef logic [28:0] ddr_addr_t;   // DDR 64-bit word address
	typedef logic [63:0] ddr_data_t;
	typedef logic [7:0]  ddr_be_t;     // One enable per DDR byte lane
	typedef logic [31:0] cart_data_t;  // Cartridge read bus
	typedef logic [16:0] bios_addr_t;  // 128 KiB boot ROM

	// ========================================
	// Address map
	// ========================================
	// Cartridge image lives at 0x80_0000 in console space
	localparam abus_t CART_BASE = 24'h80_0000;

	// Upper DDR field, puts console space at 0x3000_0000
	localparam logic [7:0] DDR_REGION = 8'b0110000;

	// Download slots from the host menu
	localparam logic [5:0] IDX_CART   = 6'd1;
	localparam logic [5:0] IDX_BIOS_A = 6'd0;
	localparam logic [5:0] IDX_BIOS_B = 6'd2;

	// Checksum skip, turns the BEQ into a BRA
	localparam bios_addr_t PATCH_ADDR = 17'h0136E;
	localparam byte_t      PATCH_BYTE = 8'h60;

	// ========================================
	// Bundles
	// ========================================
	// Host download port
	typedef struct packed {
		logic        download;  // High for the whole transfer
		logic        wr;        // One-cycle word strobe
		logic [7:0]  index;     // Slot, only 5..0 decoded
		logic [24:0] addr;      // Byte offset into the file
		word16_t     data;
	} ioctl_t;

	// One DDR access, held until accepted
	typedef struct packed {
		logic      valid;
		logic      we;    // Low for reads
		abus_t     addr;  // Byte address, bits 2..0 dropped at the port
		ddr_data_t din;
		ddr_be_t   be;
	} ddr_req_t;

endpackage

// ==== design/jag_mem_top.sv ====
/* Cartridge and boot-ROM memory glue */
module jag_mem_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	// Host download
	input  jag_mem_pkg::ioctl_t     ioctl,
	output logic                    ioctl_wait,
	// Console
	input  jag_mem_pkg::abus_t      abus,
	input  logic                    cart_ce_n,
	input  logic                    patch_en,
	output jag_mem_pkg::cart_data_t cart_q,
	output logic                    cart_wait,
	output jag_mem_pkg::byte_t      bios_q,
	// DDR
	input  logic                    ddr_busy,
	input  jag_mem_pkg::ddr_data_t  ddr_dout,
	input  logic                    ddr_dout_ready,
	output jag_mem_pkg::ddr_addr_t  ddr_addr,
	output logic                    ddr_rd,
	output logic                    ddr_we,
	output jag_mem_pkg::ddr_data_t  ddr_din,
	output jag_mem_pkg::ddr_be_t    ddr_be
);

	jag_mem_pkg::ddr_req_t load_req;   // Loader write
	jag_mem_pkg::ddr_req_t read_req;   // Cart read
	logic                  load_active;
	logic                  load_accept;
	logic                  read_accept;

	// ========================================
	// DDR masters
	// ========================================
	cart_loader u_cart_loader (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.load_accept(load_accept), .load_req(load_req), .load_active(load_active),
		.ioctl_wait(ioctl_wait));

	cart_reader u_cart_reader (.clk_sys(clk_sys), .reset(reset), .abus(abus),
		.cart_ce_n(cart_ce_n), .read_accept(read_accept), .ddr_dout(ddr_dout),
		.ddr_dout_ready(ddr_dout_ready), .read_req(read_req), .cart_wait(cart_wait),
		.cart_q(cart_q));

	// Single DDR port
	ddr_arbiter u_ddr_arbiter (.clk_sys(clk_sys), .reset(reset), .load_req(load_req),
		.load_active(load_active), .read_req(read_req), .ddr_busy(ddr_busy),
		.load_accept(load_accept), .read_accept(read_accept), .ddr_addr(ddr_addr),
		.ddr_rd(ddr_rd), .ddr_we(ddr_we), .ddr_din(ddr_din), .ddr_be(ddr_be));

	// Boot ROM in block RAM
	bios_rom u_bios_rom (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl), .abus(abus),
		.patch_en(patch_en), .bios_q(bios_q));

endmodule

// ==== jag_mem.f ====
design/jag_mem_pkg.sv
design/cart_loader.sv
design/cart_reader.sv
design/ddr_arbiter.sv
design/bios_rom.sv
design/jag_mem_top.sv
testbench/tb_jag_mem_top.sv

// ==== testbench/jag_mem_testdata.txt ====
# LOADC start count words | LOADB index start count words
# READC addr hold expected | READB addr patch_en expected | DDRCHK word expected
# Cartridge image, ten words from the cart base
LOADC 0 10
1234
5678
9ABC
DEF0
0011
2233
4455
6677
8899
AABB
DDRCHK 000 34127856BC9AF0DE
DDRCHK 001 1100332255447766
DDRCHK 002 9988BBAAC002C002
DDRCHK 003 C003C003C003C003
# Cartridge reads, hold keeps select low for an address change
READC 800000 1 34127856
READC 800004 0 BC9AF0DE
READC 800008 1 11003322
READC 80000C 1 55447766
READC 800010 0 9988BBAA
READC 800014 0 C002C002
# Boot ROM through the first slot
LOADB 0 1368 4
A1B2
C3D4
E5F6
0718
READB 01368 0 B2
READB 01369 0 A1
READB 0136A 0 D4
READB 0136B 0 C3
READB 0136E 1 60
READB 0136E 0 18
READB 0136F 1 07
# Second boot slot at the bottom
LOADB 2 0 2
BEEF
CAFE
READB 00000 0 EF
READB 00001 0 BE
READB 00002 1 FE
READB 00003 0 CA

// ==== testbench/tb_jag_mem_top.sv ====
/* Memory glue testbench */
module tb_jag_mem_top;

	logic                    clk_sys;
	logic                    reset;
	jag_mem_pkg::ioctl_t     ioctl;
	logic                    ioctl_wait;
	jag_mem_pkg::abus_t      abus;
	logic                    cart_ce_n;
	logic                    patch_en;
	jag_mem_pkg::cart_data_t cart_q;
	logic                    cart_wait;
	jag_mem_pkg::byte_t      bios_q;
	logic                    ddr_busy = 1'b0;
	jag_mem_pkg::ddr_data_t  ddr_dout = '0;
	logic                    ddr_dout_ready = 1'b0;
	jag_mem_pkg::ddr_addr_t  ddr_addr;
	logic                    ddr_rd;
	logic                    ddr_we;
	jag_mem_pkg::ddr_data_t  ddr_din;
	jag_mem_pkg::ddr_be_t    ddr_be;

	logic [63:0] ddr_mem [0:4095];  // DDR model over the low 12 word-address bits
	integer      seed = 15348;
	int          errors = 0;
	int          model_errors = 0;  // Bad DDR addresses seen by the model
	int          checks = 0;
	int          writes_seen = 0;   // DDR writes landed
	int          cycles = 0;
	int          cycle_limit = 1000000;
	int          rd_left = 0;       // Cycles until read data returns
	logic [63:0] rd_data = '0;

	jag_mem_top u_jag_mem_top (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.ioctl_wait(ioctl_wait), .abus(abus), .cart_ce_n(cart_ce_n), .patch_en(patch_en),
		.cart_q(cart_q), .cart_wait(cart_wait), .bios_q(bios_q), .ddr_busy(ddr_busy),
		.ddr_dout(ddr_dout), .ddr_dout_ready(ddr_dout_ready), .ddr_addr(ddr_addr),
		.ddr_rd(ddr_rd), .ddr_we(ddr_we), .ddr_din(ddr_din), .ddr_be(ddr_be));

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================
	// DDR model
	// ========================================
	initial begin
		for (int i = 0; i < 4096; i++)
			ddr_mem[i] = {4{4'hC, 12'(i)}};  // Fill tagged with word address
	end

	always @(posedge clk_sys) begin
		logic [63:0] w;
		if (reset) begin
			ddr_busy       <= 1'b0;
			ddr_dout_ready <= 1'b0;
			rd_left        <= 0;
		end else begin
			ddr_busy       <= ({$random(seed)} % 4) == 0;  // Busy about a quarter of cycles
			ddr_dout_ready <= 1'b0;
			if (ddr_we || ddr_rd) begin
				// Only the cart space at region 0x30 and console 0x80_0000 up
				assert (ddr_addr[28:12] == {8'h30, 9'h100}) else begin
					$display("DDR access outside the cartridge region, address %h", ddr_addr);
					model_errors <= model_errors + 1;
				end
			end
			if (ddr_we) begin
				w = ddr_mem[ddr_addr[11:0]];
				for (int b = 0; b < 8; b++)
					if (ddr_be[b])
						w[8*b +: 8] = ddr_din[8*b +: 8];
				ddr_mem[ddr_addr[11:0]] = w;
				writes_seen <= writes_seen + 1;
			end
			if (rd_left != 0) begin
				rd_left <= rd_left - 1;
				if (rd_left == 1) begin
					ddr_dout_ready <= 1'b1;  // Single ready pulse
					ddr_dout       <= rd_data;
				end
			end
			if (ddr_rd) begin
				rd_left <= 2 + ({$random(seed)} % 8);  // 2 to 9 cycles
				rd_data <= ddr_mem[ddr_addr[11:0]];
			end
		end
	end

	// Watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		checks++;
		assert (exp == got) else begin
			$display("Error: %s expected %h actual %h", name, exp, got);
			errors++;
		end
	endtask

	// Loads one cartridge image a host word at a time
	task automatic load_cart(input int fd);
		logic [24:0] start;
		int          n;
		int          base_writes;
		logic [15:0] word;
		void'($fscanf(fd, "%h %d", start, n));
		base_writes = writes_seen;
		@(posedge clk_sys);
		ioctl.download <= 1'b1;
		ioctl.index    <= {2'b00, jag_mem_pkg::IDX_CART};
		@(posedge clk_sys);
		for (int i = 0; i < n; i++) begin
			void'($fscanf(fd, "%h", word));
			@(posedge clk_sys);
			ioctl.wr   <= 1'b1;
			ioctl.addr <= start + 25'(2 * i);
			ioctl.data <= word;
			@(posedge clk_sys);
			ioctl.wr <= 1'b0;
			@(negedge clk_sys);
			check_value("LOADC ioctl_wait after wr", 64'd1, 64'(ioctl_wait));
			while (ioctl_wait)
				@(negedge clk_sys);
			check_value("LOADC write landed", 64'(i + 1), 64'(writes_seen - base_writes));
		end
		@(posedge clk_sys);
		ioctl.download <= 1'b0;
		@(negedge clk_sys);
		check_value("LOADC write count", 64'(n), 64'(writes_seen - base_writes));
	endtask

	// Boot ROM bytes land two cycles after each wr
	task automatic load_bios(input int fd);
		logic [5:0]  idx;
		logic [24:0] start;
		int          n;
		logic [15:0] word;
		void'($fscanf(fd, "%h %h %d", idx, start, n));
		@(posedge clk_sys);
		ioctl.download <= 1'b1;
		ioctl.index    <= {2'b00, idx};
		for (int i = 0; i < n; i++) begin
			void'($fscanf(fd, "%h", word));
			@(posedge clk_sys);
			ioctl.wr   <= 1'b1;
			ioctl.addr <= start + 25'(2 * i);
			ioctl.data <= word;
			@(posedge clk_sys);
			ioctl.wr <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end
		ioctl.download <= 1'b0;
	endtask

	task automatic read_cart(input int fd);
		logic [23:0] addr;
		int          hold;
		logic [31:0] exp;
		void'($fscanf(fd, "%h %d %h", addr, hold, exp));
		@(posedge clk_sys);
		abus      <= addr;
		cart_ce_n <= 1'b0;
		@(negedge clk_sys);  // Trigger cycle
		@(negedge clk_sys);
		check_value($sformatf("READC %h cart_wait", addr), 64'd1, 64'(cart_wait));
		while (!ddr_dout_ready) begin
			assert (cart_wait) else begin
				$display("cart_wait dropped before read data returned at %h", addr);
				errors++;
			end
			@(negedge clk_sys);
		end
		check_value($sformatf("READC %h", addr), 64'(exp), 64'(cart_q));
		check_value($sformatf("READC %h wait in data cycle", addr), 64'd0, 64'(cart_wait));
		if (hold == 0) begin
			@(posedge clk_sys);
			cart_ce_n <= 1'b1;
		end
	endtask

	task automatic read_bios(input int fd);
		logic [16:0] addr;
		logic        pen;
		logic [7:0]  exp;
		void'($fscanf(fd, "%h %h %h", addr, pen, exp));
		@(posedge clk_sys);
		abus     <= 24'(addr);
		patch_en <= pen;
		@(posedge clk_sys);
		@(negedge clk_sys);  // Registered read
		check_value($sformatf("READB %h patch %b", addr, pen), 64'(exp), 64'(bios_q));
	endtask

	// ========================================
	// Command player
	// ========================================
	initial begin
		int          fd;
		int          lines;
		string       cmd;
		string       rest;
		logic [11:0] idx;
		logic [63:0] exp;
		ioctl     = '0;
		abus      = '0;
		cart_ce_n = 1'b1;
		patch_en  = 1'b0;
		reset     = 1'b1;
		lines     = 0;
		fd = $fopen("testbench/jag_mem_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
			errors++;
		end else begin
			while ($fgets(rest, fd) != 0)
				lines++;
			$fclose(fd);
			cycle_limit = 200 * lines + 1000;
			fd = $fopen("testbench/jag_mem_testdata.txt", "r");
		end
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("reset ioctl_wait", 64'd0, 64'(ioctl_wait));
		check_value("reset cart_wait", 64'd0, 64'(cart_wait));
		check_value("reset ddr_rd", 64'd0, 64'(ddr_rd));
		check_value("reset ddr_we", 64'd0, 64'(ddr_we));
		if (fd != 0) begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				if (cmd.substr(0, 0) == "#")
					void'($fgets(rest, fd));
				else if (cmd == "LOADC")
					load_cart(fd);
				else if (cmd == "LOADB")
					load_bios(fd);
				else if (cmd == "READC")
					read_cart(fd);
				else if (cmd == "READB")
					read_bios(fd);
				else if (cmd == "DDRCHK") begin
					void'($fscanf(fd, "%h %h", idx, exp));
					@(negedge clk_sys);
					check_value($sformatf("DDRCHK %h", idx), exp, ddr_mem[idx]);
				end else begin
					$display("Unknown command %s in test data", cmd);
					errors++;
				end
				@(posedge clk_sys);  // Idle cycle between commands
			end
			$fclose(fd);
		end
		errors = errors + model_errors;
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
